// File: filelist.f
src/backtrack_pkg.sv
src/backtrack_fifo.sv
src/backtrack_route_control.sv
src/backtrack_lane_demux.sv
src/backtrack_lanes_top.sv
verification/backtrack_lanes_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the backtrack lanes testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_EXE=backtrack_lanes_sim

verilator --binary --timing -Wno-fatal -f filelist.f --top-module backtrack_lanes_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Verdict comes from the log
if grep -q "TB FAILED" "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

// File: src/backtrack_fifo.sv
/*
 * Backtrack FIFO
 * Synchronous circular buffer with registered read data and count-based prog_full
 */

module backtrack_fifo (
    input  logic                            ap_clk,
    input  logic                            areset_backtrack,
    input  logic                            wr_en,
    input  backtrack_pkg::backtrack_packet_t wr_data,
    input  logic                            rd_en,
    output backtrack_pkg::backtrack_packet_t rd_data,
    output logic                            rd_valid,
    output logic                            empty,
    output logic                            full,
    output logic                            prog_full
);

    // --------------------
    // Storage and pointers
    // --------------------

    backtrack_pkg::backtrack_packet_t mem [backtrack_pkg::FIFO_DEPTH];

    backtrack_pkg::fifo_ptr_t   wr_ptr;
    backtrack_pkg::fifo_ptr_t   rd_ptr;
    backtrack_pkg::fifo_count_t count;
    backtrack_pkg::fifo_count_t count_next;

    // Accepted operations only
    logic do_write;
    logic do_read;

    // Wrap at the last entry, depth need not be a power of two
    function automatic backtrack_pkg::fifo_ptr_t ptr_inc(input backtrack_pkg::fifo_ptr_t ptr);
        if (ptr == backtrack_pkg::fifo_ptr_t'(backtrack_pkg::FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Flags straight from the occupancy
    assign empty = (count == '0);
    assign full  = (count == backtrack_pkg::fifo_count_t'(backtrack_pkg::FIFO_DEPTH));

    // Write when full and read when empty are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    // Occupancy after this cycle
    always_comb begin
        count_next = count;
        if (do_write & ~do_read) begin
            count_next = count + 1'b1;
        end else if (do_read & ~do_write) begin
            count_next = count - 1'b1;
        end
    end

    // --------------------
    // Control state
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rd_valid  <= 1'b0;
            prog_full <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count_next;
            // One pulse per accepted pop
            rd_valid <= do_read;
            // Compared on the next count so the flag tracks occupancy without lag
            prog_full <= (count_next >= backtrack_pkg::PROG_FULL_LEVEL);
        end
    end

    // --------------------
    // Data path
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
        // Popped entry shows up one cycle after the pop
        if (do_read) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

// File: src/backtrack_lane_demux.sv
/*
 * Backtrack lane demux
 * Copies each popped response packet into every selected lane FIFO
 */

module backtrack_lane_demux (
    input  logic                             ap_clk,
    input  logic                             areset_backtrack,
    input  logic                             rd_valid,
    input  backtrack_pkg::backtrack_packet_t rd_data,
    input  backtrack_pkg::lane_mask_t        lane_select,
    output backtrack_pkg::lane_mask_t        lane_wr_en,
    output backtrack_pkg::backtrack_packet_t lane_wr_data
);

    // --------------------
    // Write strobes
    // --------------------

    // Strobe per lane for this packet
    backtrack_pkg::lane_mask_t lane_hit;

    // Empty select drops the packet
    always_comb begin
        for (int lane = 0; lane < backtrack_pkg::NUM_LANES; lane++) begin
            lane_hit[lane] = rd_valid & lane_select[lane];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            lane_wr_en <= '0;
        end else begin
            lane_wr_en <= lane_hit;
        end
    end

    // --------------------
    // Shared data bus
    // --------------------

    // Captured with the strobe, all lanes see the same word
    always_ff @(posedge ap_clk) begin
        if (rd_valid) begin
            lane_wr_data <= rd_data;
        end
    end

endmodule

// File: src/backtrack_lanes_top.sv
/*
 * Backtrack lanes top
 * Response FIFO, route control, demux and lane FIFOs of one bundle
 */

module backtrack_lanes_top #(
    parameter int ID_BUNDLE = 0
) (
    input  logic                             ap_clk,
    input  logic                             areset_backtrack,
    input  logic                             configure_route_valid,
    input  backtrack_pkg::bundle_sel_t       configure_route_bundle,
    input  backtrack_pkg::lane_mask_t        configure_route_lanes,
    input  logic                             engine_wr_en,
    input  backtrack_pkg::backtrack_packet_t engine_data,
    input  logic                             engine_rd_req,
    input  backtrack_pkg::lane_mask_t        lane_rd_en,
    output logic                             engine_prog_full,
    output backtrack_pkg::backtrack_packet_t lane_data [backtrack_pkg::NUM_LANES],
    output backtrack_pkg::lane_mask_t        lane_empty,
    output backtrack_pkg::lane_mask_t        lane_prog_full
);

    // Response FIFO side
    backtrack_pkg::backtrack_packet_t response_rd_data;
    logic                             response_rd_valid;
    logic                             response_empty;
    logic                             fifo_rd_en;

    // Lane side
    backtrack_pkg::lane_mask_t        lane_select;
    backtrack_pkg::lane_mask_t        lane_wr_en;
    backtrack_pkg::backtrack_packet_t lane_wr_data;

    // --------------------
    // Engine responses
    // --------------------

    backtrack_fifo response_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .wr_en            (engine_wr_en),
        .wr_data          (engine_data),
        .rd_en            (fifo_rd_en),
        .rd_data          (response_rd_data),
        .rd_valid         (response_rd_valid),
        .empty            (response_empty),
        .full             (),
        .prog_full        (engine_prog_full)
    );

    // --------------------
    // Routing
    // --------------------

    backtrack_route_control #(
        .ID_BUNDLE (ID_BUNDLE)
    ) route_control_inst (
        .ap_clk                 (ap_clk),
        .areset_backtrack       (areset_backtrack),
        .configure_route_valid  (configure_route_valid),
        .configure_route_bundle (configure_route_bundle),
        .configure_route_lanes  (configure_route_lanes),
        .engine_rd_req          (engine_rd_req),
        .response_empty         (response_empty),
        .response_rd_valid      (response_rd_valid),
        .lane_prog_full         (lane_prog_full),
        .fifo_rd_en             (fifo_rd_en),
        .lane_select            (lane_select)
    );

    backtrack_lane_demux lane_demux_inst (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .rd_valid         (response_rd_valid),
        .rd_data          (response_rd_data),
        .lane_select      (lane_select),
        .lane_wr_en       (lane_wr_en),
        .lane_wr_data     (lane_wr_data)
    );

    // --------------------
    // Lane FIFOs
    // --------------------

    // Local lanes first, forward lane last
    for (genvar lane = 0; lane < backtrack_pkg::NUM_LANES; lane++) begin : g_lane
        backtrack_fifo lane_fifo_inst (
            .ap_clk           (ap_clk),
            .areset_backtrack (areset_backtrack),
            .wr_en            (lane_wr_en[lane]),
            .wr_data          (lane_wr_data),
            .rd_en            (lane_rd_en[lane]),
            .rd_data          (lane_data[lane]),
            .rd_valid         (),
            .empty            (lane_empty[lane]),
            .full             (),
            .prog_full        (lane_prog_full[lane])
        );
    end

endmodule

// File: src/backtrack_pkg.sv
/*
 * Backtrack response path definitions
 * Lane and bundle counts, FIFO sizing, packet, mask and route state types
 */

package backtrack_pkg;

    // --------------------
    // Sizes
    // --------------------

    // Backtrack lanes per bundle, last one forwards to the next bundle
    localparam int NUM_LANES = 4;

    // Bundles on the ring, one bit each in the bundle field
    localparam int NUM_BUNDLES = 4;

    // Response packet width
    localparam int PACKET_WIDTH = 32;

    // Entries in every FIFO of the path
    localparam int FIFO_DEPTH = 16;

    // Pointer and occupancy widths
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // --------------------
    // Types
    // --------------------

    // Vertex identifier or payload word
    typedef logic [PACKET_WIDTH-1:0] backtrack_packet_t;

    // One-hot bundle identifier
    typedef logic [NUM_BUNDLES-1:0] bundle_sel_t;

    // One bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // FIFO pointer and occupancy
    typedef logic [FIFO_ADDR_WIDTH-1:0] fifo_ptr_t;
    typedef logic [FIFO_COUNT_WIDTH-1:0] fifo_count_t;

    // Route control FSM
    typedef enum logic [1:0] {
        ROUTE_UNCONFIGURED,
        ROUTE_LOCAL,
        ROUTE_FORWARD,
        ROUTE_DISCARD
    } route_state_t;

    // --------------------
    // Derived constants
    // --------------------

    // Occupancy where prog_full rises, four entries of slack for the loop delay
    localparam fifo_count_t PROG_FULL_LEVEL = fifo_count_t'(12);

    // Index and mask of the forward lane
    localparam int FORWARD_LANE = NUM_LANES - 1;
    localparam lane_mask_t FORWARD_LANE_MASK = lane_mask_t'(1) << FORWARD_LANE;

endpackage

// File: src/backtrack_route_control.sv
/*
 * Backtrack route control
 * Holds the route, samples lane fullness and decides when the response FIFO pops
 */

module backtrack_route_control #(
    parameter int ID_BUNDLE = 0
) (
    input  logic                       ap_clk,
    input  logic                       areset_backtrack,
    input  logic                       configure_route_valid,
    input  backtrack_pkg::bundle_sel_t configure_route_bundle,
    input  backtrack_pkg::lane_mask_t  configure_route_lanes,
    input  logic                       engine_rd_req,
    input  logic                       response_empty,
    input  logic                       response_rd_valid,
    input  backtrack_pkg::lane_mask_t  lane_prog_full,
    output logic                       fifo_rd_en,
    output backtrack_pkg::lane_mask_t  lane_select
);

    // One-hot code of this bundle
    backtrack_pkg::bundle_sel_t local_bundle;
    assign local_bundle = backtrack_pkg::bundle_sel_t'(1) << ID_BUNDLE;

    // Route request waiting to be applied
    logic                       cfg_pending;
    backtrack_pkg::bundle_sel_t cfg_bundle_q;
    backtrack_pkg::lane_mask_t  cfg_lanes_q;
    backtrack_pkg::route_state_t cfg_state;

    // Active route
    backtrack_pkg::route_state_t route_state;
    backtrack_pkg::lane_mask_t   route_lanes;
    backtrack_pkg::lane_mask_t   dest_mask;

    // Sampled gating inputs
    logic                      engine_rd_req_q;
    backtrack_pkg::lane_mask_t lane_prog_full_q;

    logic route_idle;
    logic pop_allow;

    // --------------------
    // Route decode
    // --------------------

    // Empty mask discards, else local or forward by the bundle field
    always_comb begin
        if (cfg_lanes_q == '0) begin
            cfg_state = backtrack_pkg::ROUTE_DISCARD;
        end else if (cfg_bundle_q == local_bundle) begin
            cfg_state = backtrack_pkg::ROUTE_LOCAL;
        end else begin
            cfg_state = backtrack_pkg::ROUTE_FORWARD;
        end
    end

    // Destination lanes of the active route
    always_comb begin
        case (route_state)
            backtrack_pkg::ROUTE_LOCAL:
                dest_mask = route_lanes & ~backtrack_pkg::FORWARD_LANE_MASK;
            backtrack_pkg::ROUTE_FORWARD:
                dest_mask = backtrack_pkg::FORWARD_LANE_MASK;
            default:
                dest_mask = '0;
        endcase
    end

    // No pop issued and no packet leaving the response FIFO
    assign route_idle = ~fifo_rd_en & ~response_rd_valid;

    // Only lanes on the route gate the pop, pending change holds it
    assign pop_allow = (route_state != backtrack_pkg::ROUTE_UNCONFIGURED) & ~cfg_pending &
                       engine_rd_req_q & ~response_empty &
                       ~(|(dest_mask & lane_prog_full_q));

    // --------------------
    // Route registers
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            cfg_pending <= 1'b0;
            route_state <= backtrack_pkg::ROUTE_UNCONFIGURED;
            route_lanes <= '0;
        end else begin
            // New strobe wins over an applied one in the same cycle
            if (configure_route_valid) begin
                cfg_pending <= 1'b1;
            end else if (cfg_pending & route_idle) begin
                cfg_pending <= 1'b0;
            end
            // Switch only with the read pipeline empty
            if (cfg_pending & route_idle) begin
                route_state <= cfg_state;
                route_lanes <= cfg_lanes_q;
            end
        end
    end

    // Route payload
    always_ff @(posedge ap_clk) begin
        if (configure_route_valid) begin
            cfg_bundle_q <= configure_route_bundle;
            cfg_lanes_q  <= configure_route_lanes;
        end
    end

    // --------------------
    // Sampling and pop
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            engine_rd_req_q  <= 1'b0;
            lane_prog_full_q <= '0;
            fifo_rd_en       <= 1'b0;
            lane_select      <= '0;
        end else begin
            engine_rd_req_q  <= engine_rd_req;
            lane_prog_full_q <= lane_prog_full;
            fifo_rd_en       <= pop_allow;
            lane_select      <= dest_mask;
        end
    end

endmodule

// File: verification/backtrack_lanes_tb.sv
/*
 * Backtrack lanes testbench
 * Table-driven routes with LCG packets, per-lane scoreboard and watchdog
 */

module backtrack_lanes_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------
    // Constants and table
    // --------------------

    localparam int CLK_PERIOD = 8;
    localparam int TB_BUNDLE = 1;
    localparam int NUM_ROWS = 9;
    // Cycle budgets
    localparam int PACKET_CYCLES = 40;
    localparam int HOLD_CYCLES = 40;
    localparam int SETTLE_CYCLES = 4;
    localparam int MARGIN_CYCLES = 500;
    localparam backtrack_pkg::lane_mask_t LANES_ALL = '1;

    // Bundle 0 means the row sends no route strobe
    // Dest holds the lanes that must receive every packet of the route
    typedef struct packed {
        backtrack_pkg::bundle_sel_t bundle;
        backtrack_pkg::lane_mask_t  lanes;
        backtrack_pkg::lane_mask_t  dest;
        logic [7:0]                 count;
        logic                       rd_req;
        logic                       stall;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'b0000, 4'b0000, 4'b0000, 8'd6,  1'b1, 1'b0},  // no route yet
        '{4'b0010, 4'b0011, 4'b0011, 8'd10, 1'b1, 1'b0},
        '{4'b0010, 4'b1110, 4'b0110, 8'd12, 1'b1, 1'b0},  // forward bit dropped on local
        '{4'b0100, 4'b0001, 4'b1000, 8'd12, 1'b1, 1'b0},
        '{4'b1000, 4'b0110, 4'b1000, 8'd8,  1'b1, 1'b0},
        '{4'b0010, 4'b0000, 4'b0000, 8'd10, 1'b1, 1'b0},  // discard
        '{4'b0010, 4'b0101, 4'b0101, 8'd20, 1'b1, 1'b1},  // stalled lanes
        '{4'b0001, 4'b1000, 4'b1000, 8'd12, 1'b0, 1'b0},  // engine holds responses
        '{4'b0010, 4'b0100, 4'b0100, 8'd4,  1'b1, 1'b0}
    };

    // DUT signals
    logic                             ap_clk;
    logic                             areset_backtrack;
    logic                             configure_route_valid;
    backtrack_pkg::bundle_sel_t       configure_route_bundle;
    backtrack_pkg::lane_mask_t        configure_route_lanes;
    logic                             engine_wr_en;
    backtrack_pkg::backtrack_packet_t engine_data;
    logic                             engine_rd_req;
    backtrack_pkg::lane_mask_t        lane_rd_en;
    logic                             engine_prog_full;
    backtrack_pkg::backtrack_packet_t lane_data [backtrack_pkg::NUM_LANES];
    backtrack_pkg::lane_mask_t        lane_empty;
    backtrack_pkg::lane_mask_t        lane_prog_full;

    // Scoreboard state
    backtrack_pkg::backtrack_packet_t expected_q [backtrack_pkg::NUM_LANES][$];
    backtrack_pkg::backtrack_packet_t held_q [$];
    backtrack_pkg::lane_mask_t        pop_seen = '0;
    backtrack_pkg::lane_mask_t        route_dest = '0;
    logic                             route_set = 1'b0;
    logic [31:0]                      lcg_state = 32'h57e03d24;
    int                               error_count = 0;
    int                               rows_passed = 0;
    int                               rows_failed = 0;

    backtrack_lanes_top #(
        .ID_BUNDLE (TB_BUNDLE)
    ) backtrack_lanes_top_inst (
        .ap_clk                 (ap_clk),
        .areset_backtrack       (areset_backtrack),
        .configure_route_valid  (configure_route_valid),
        .configure_route_bundle (configure_route_bundle),
        .configure_route_lanes  (configure_route_lanes),
        .engine_wr_en           (engine_wr_en),
        .engine_data            (engine_data),
        .engine_rd_req          (engine_rd_req),
        .lane_rd_en             (lane_rd_en),
        .engine_prog_full       (engine_prog_full),
        .lane_data              (lane_data),
        .lane_empty             (lane_empty),
        .lane_prog_full         (lane_prog_full)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic all_delivered();
        for (int lane = 0; lane < backtrack_pkg::NUM_LANES; lane++) begin
            if (expected_q[lane].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic int total_packets();
        int total;
        total = 0;
        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            total += int'(ROWS[idx].count);
        end
        return total;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // One copy per lane on the route
    task automatic expect_packet(input backtrack_pkg::backtrack_packet_t packet,
                                 input backtrack_pkg::lane_mask_t dest);
        for (int lane = 0; lane < backtrack_pkg::NUM_LANES; lane++) begin
            if (dest[lane]) begin
                expected_q[lane].push_back(packet);
            end
        end
    endtask

    // Engine push held off while the response FIFO warns
    task automatic push_packet(input backtrack_pkg::backtrack_packet_t packet);
        @(negedge ap_clk);
        while (engine_prog_full) begin
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        engine_wr_en <= 1'b1;
        engine_data  <= packet;
        @(posedge ap_clk);
        engine_wr_en <= 1'b0;
    endtask

    // --------------------
    // Row sequence
    // --------------------

    task automatic run_row(input int idx);
        row_t                             row;
        backtrack_pkg::backtrack_packet_t packet;
        logic                             delivering;
        int                               errors_before;
        int                               budget;
        int                               waited;
        row = ROWS[idx];
        errors_before = error_count;
        budget = (int'(row.count) + held_q.size()) * PACKET_CYCLES;
        @(posedge ap_clk);
        engine_rd_req <= row.rd_req;
        lane_rd_en    <= row.stall ? '0 : LANES_ALL;
        if (row.bundle != '0) begin
            configure_route_valid  <= 1'b1;
            configure_route_bundle <= row.bundle;
            configure_route_lanes  <= row.lanes;
            route_set  = 1'b1;
            route_dest = row.dest;
        end
        @(posedge ap_clk);
        configure_route_valid <= 1'b0;
        delivering = route_set & row.rd_req;
        // Held packets take the first route that drains them
        if (delivering) begin
            while (held_q.size() != 0) begin
                expect_packet(held_q.pop_front(), route_dest);
            end
        end
        for (int n = 0; n < int'(row.count); n++) begin
            packet = lcg_state;
            lcg_state = lcg_next(lcg_state);
            if (delivering) begin
                expect_packet(packet, route_dest);
            end else begin
                held_q.push_back(packet);
            end
            push_packet(packet);
        end
        if (!delivering) begin
            repeat (HOLD_CYCLES) @(negedge ap_clk);
            check_value(32'(lane_empty), 32'(LANES_ALL), "lanes empty while responses held");
            if (held_q.size() >= int'(backtrack_pkg::PROG_FULL_LEVEL)) begin
                check_value(32'(engine_prog_full), 32'd1, "engine_prog_full with responses held");
            end
        end else begin
            // Stalled lanes must warn before they are drained
            if (row.stall) begin
                waited = 0;
                @(negedge ap_clk);
                while ((lane_prog_full & route_dest) != route_dest && waited < budget) begin
                    @(negedge ap_clk);
                    waited++;
                end
                check_value(32'(lane_prog_full & route_dest), 32'(route_dest),
                            "lane_prog_full on stalled lanes");
                @(posedge ap_clk);
                lane_rd_en <= LANES_ALL;
            end
            waited = 0;
            @(negedge ap_clk);
            while (!(all_delivered() && backtrack_lanes_top_inst.response_empty) &&
                   waited < budget) begin
                @(negedge ap_clk);
                waited++;
            end
            if (waited >= budget) begin
                error_count++;
                $display("Row %0d: packets still missing after %0d cycles", idx, budget);
            end
            repeat (SETTLE_CYCLES) @(negedge ap_clk);
            check_value(32'(lane_empty), 32'(LANES_ALL), "lanes empty after drain");
        end
        if (error_count == errors_before) begin
            rows_passed++;
            $display("Row %0d: pass, %0d packets, bundle %b lanes %b", idx, row.count,
                     row.bundle, row.lanes);
        end else begin
            rows_failed++;
            $display("Row %0d: fail, %0d errors", idx, error_count - errors_before);
        end
    endtask

    // Lane pops seen at one falling edge are compared at the next
    always @(negedge ap_clk) begin
        for (int lane = 0; lane < backtrack_pkg::NUM_LANES; lane++) begin
            if (pop_seen[lane]) begin
                if (expected_q[lane].size() == 0) begin
                    error_count++;
                    $display("Lane %0d delivered %h at %0d ns with no packet expected",
                             lane, lane_data[lane], $time);
                end else begin
                    check_value(lane_data[lane], expected_q[lane].pop_front(),
                                $sformatf("lane %0d packet in order", lane));
                end
            end
            pop_seen[lane] = ~areset_backtrack & lane_rd_en[lane] & ~lane_empty[lane];
        end
    end

    initial begin : watchdog
        int limit_cycles;
        limit_cycles = total_packets() * PACKET_CYCLES + NUM_ROWS * HOLD_CYCLES + MARGIN_CYCLES;
        repeat (limit_cycles) @(posedge ap_clk);
        $display("Watchdog: run timed out after %0d cycles", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        areset_backtrack       = 1'b1;
        configure_route_valid  = 1'b0;
        configure_route_bundle = '0;
        configure_route_lanes  = '0;
        engine_wr_en           = 1'b0;
        engine_data            = '0;
        engine_rd_req          = 1'b0;
        lane_rd_en             = '0;
        repeat (3) @(posedge ap_clk);
        areset_backtrack <= 1'b0;
        @(negedge ap_clk);
        check_value(32'(lane_empty), 32'(LANES_ALL), "lane_empty after reset");
        check_value(32'(lane_prog_full), 32'd0, "lane_prog_full after reset");
        check_value(32'(engine_prog_full), 32'd0, "engine_prog_full after reset");
        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            run_row(idx);
        end
        $display("Summary: %0d rows passed, %0d rows failed, %0d errors", rows_passed,
                 rows_failed, error_count);
        if (error_count == 0 && rows_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
